//--- ara_soc.sv
// SoC top level
// Core and vector requester ports into the crossbar, with L2, UART bridge
// and control registers behind it

`timescale 1ns/1ps
`default_nettype none

module ara_soc (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   core_cyc_i,
  input  logic                   core_stb_i,
  input  logic                   core_we_i,
  input  soc_bus_pkg::addr_t     core_adr_i,
  input  soc_bus_pkg::data_t     core_dat_i,
  input  soc_bus_pkg::sel_t      core_sel_i,
  output soc_bus_pkg::data_t     core_dat_o,
  output logic                   core_ack_o,
  output logic                   core_err_o,
  input  logic                   vec_cyc_i,
  input  logic                   vec_stb_i,
  input  logic                   vec_we_i,
  input  soc_bus_pkg::addr_t     vec_adr_i,
  input  soc_bus_pkg::data_t     vec_dat_i,
  input  soc_bus_pkg::sel_t      vec_sel_i,
  output soc_bus_pkg::data_t     vec_dat_o,
  output logic                   vec_ack_o,
  output logic                   vec_err_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output soc_bus_pkg::addr_t     uart_paddr_o,
  output soc_bus_pkg::apb_data_t uart_pwdata_o,
  input  soc_bus_pkg::apb_data_t uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i,
  output soc_regs_pkg::reg64_t   exit_o,
  output soc_regs_pkg::reg64_t   hw_cnt_en_o
);

  soc_wb_if l2_bus ();
  soc_wb_if uart_bus ();
  soc_wb_if ctrl_bus ();

  //////////////////////////////////////////////////
  // Crossbar
  //////////////////////////////////////////////////

  // Requester ports and slave links share their names with the crossbar
  soc_xbar i_soc_xbar (.*);

  //////////////////////////////////////////////////
  // Slaves
  //////////////////////////////////////////////////

  l2_mem i_l2_mem (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .bus    (l2_bus )
  );

  uart_apb_bridge i_uart_apb_bridge (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .bus           (uart_bus      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .bus        (ctrl_bus   ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

`default_nettype wire

//--- ctrl_regs.sv
// Control registers
// Exit code and counter enable registers, read-only DRAM window bounds

`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  soc_wb_if.slave              bus,
  output soc_regs_pkg::reg64_t exit_o,
  output soc_regs_pkg::reg64_t hw_cnt_en_o
);

  soc_regs_pkg::ctrl_offset_t offset;
  soc_regs_pkg::reg64_t       exit_q;
  soc_regs_pkg::reg64_t       cnt_en_q;
  soc_regs_pkg::reg64_t       rdata_d;
  soc_regs_pkg::reg64_t       rdata_q;
  logic                       access;
  logic                       bad;
  logic                       ack_q;
  logic                       err_q;

  assign offset = bus.adr[soc_regs_pkg::CtrlOffsetWidth-1:0];
  assign access = bus.cyc & bus.stb & ~ack_q & ~err_q;

  always_comb begin
    rdata_d = '0;
    bad     = 1'b0;
    case (offset)
      soc_regs_pkg::CtrlExitOffset: begin
        rdata_d = exit_q;
      end
      soc_regs_pkg::CtrlCntEnOffset: begin
        rdata_d = cnt_en_q;
      end
      soc_regs_pkg::CtrlDramBaseOffset: begin
        rdata_d = soc_regs_pkg::reg64_t'(soc_bus_pkg::DramBase);
        bad     = bus.we;
      end
      soc_regs_pkg::CtrlDramEndOffset: begin
        rdata_d = soc_regs_pkg::reg64_t'(soc_bus_pkg::DramBase + soc_bus_pkg::DramLength);
        bad     = bus.we;
      end
      default: begin
        bad = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      ack_q <= access & ~bad;
      err_q <= access & bad;
      if (access && bus.we && offset == soc_regs_pkg::CtrlExitOffset) begin
        exit_q <= soc_bus_pkg::merge_bytes(exit_q, bus.dat_w, bus.sel);
      end
      if (access && bus.we && offset == soc_regs_pkg::CtrlCntEnOffset) begin
        cnt_en_q <= soc_bus_pkg::merge_bytes(cnt_en_q, bus.dat_w, bus.sel);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.dat_r   = rdata_q;
  assign bus.ack     = ack_q;
  assign bus.err     = err_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

`default_nettype wire

//--- l2_mem.sv
// L2 memory
// Single-port word memory behind the DRAM window, wraps every L2NumWords words,
// byte-select writes and a one-cycle acknowledge

`timescale 1ns/1ps
`default_nettype none

module l2_mem (
  input  logic      clk_i,
  input  logic      rst_n_i,
  soc_wb_if.slave   bus
);

  typedef logic [soc_bus_pkg::L2IdxWidth-1:0] l2_idx_t;

  soc_bus_pkg::data_t mem [soc_bus_pkg::L2NumWords];
  soc_bus_pkg::data_t rdata_q;
  l2_idx_t            idx;
  logic               access;
  logic               ack_q;

  // Word index sits just above the byte offset
  assign idx    = bus.adr[soc_bus_pkg::ByteOffWidth +: soc_bus_pkg::L2IdxWidth];
  assign access = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= mem[idx];
      if (bus.we) begin
        mem[idx] <= soc_bus_pkg::merge_bytes(mem[idx], bus.dat_w, bus.sel);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

  // Master holds the same request through the acknowledge
  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.ack |-> bus.cyc && bus.stb && $stable(bus.adr) && $stable(bus.we));

endmodule

`default_nettype wire

//--- project.f
soc_bus_pkg.sv
soc_regs_pkg.sv
soc_wb_if.sv
soc_xbar.sv
l2_mem.sv
uart_apb_bridge.sv
ctrl_regs.sv
ara_soc.sv
tb_ara_soc.sv

//--- run.sh
#!/bin/sh
# Build the SoC testbench with Verilator, run it and check for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_ara_soc -Mdir obj_dir -f project.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_ara_soc)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1

//--- soc_bus_pkg.sv
// SoC bus package
// Address map, Wishbone widths and the vector types shared by the interconnect

`default_nettype none

package soc_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned SelWidth  = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [SelWidth-1:0]  sel_t;

  // Memory map
  localparam addr_t DramBase   = 32'h8000_0000;
  localparam addr_t DramLength = 32'h4000_0000;
  localparam addr_t UartBase   = 32'hC000_0000;
  localparam addr_t UartLength = 32'h0000_1000;
  localparam addr_t CtrlBase   = 32'hD000_0000;
  localparam addr_t CtrlLength = 32'h0000_1000;

  // L2 geometry
  localparam int unsigned L2NumWords   = 1024;
  localparam int unsigned L2IdxWidth   = $clog2(L2NumWords);
  localparam int unsigned ByteOffWidth = $clog2(SelWidth);

  localparam int unsigned ApbAddrWidth = 32;
  localparam int unsigned ApbDataWidth = 32;

  typedef logic [ApbDataWidth-1:0] apb_data_t;

  typedef enum logic [1:0] {
    SlaveL2,
    SlaveUart,
    SlaveCtrl,
    SlaveNone
  } slave_e;

  // Byte-lane merge of a write into an existing word
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, sel_t sel);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < SelWidth; b++) begin
      if (sel[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- soc_regs_pkg.sv
// Control register package
// Register offsets inside the control window and the register type

`default_nettype none

package soc_regs_pkg;

  localparam int unsigned CtrlOffsetWidth = $clog2(soc_bus_pkg::CtrlLength);

  typedef logic [CtrlOffsetWidth-1:0] ctrl_offset_t;
  typedef logic [63:0]                reg64_t;

  localparam ctrl_offset_t CtrlExitOffset     = 'h00;
  localparam ctrl_offset_t CtrlCntEnOffset    = 'h08;
  localparam ctrl_offset_t CtrlDramBaseOffset = 'h10;
  localparam ctrl_offset_t CtrlDramEndOffset  = 'h18;

endpackage

`default_nettype wire

//--- soc_wb_if.sv
// Wishbone classic bus
// One crossbar-to-slave link with master and slave views

`timescale 1ns/1ps
`default_nettype none

interface soc_wb_if;

  logic               cyc;
  logic               stb;
  logic               we;
  soc_bus_pkg::addr_t adr;
  soc_bus_pkg::data_t dat_w;
  soc_bus_pkg::sel_t  sel;
  soc_bus_pkg::data_t dat_r;
  logic               ack;
  logic               err;

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

//--- soc_xbar.sv
// SoC crossbar
// Round-robin arbitration of the core and vector requesters onto one bus,
// address decode to L2, UART or control registers, error on unmapped space

`timescale 1ns/1ps
`default_nettype none

module soc_xbar (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               core_cyc_i,
  input  logic               core_stb_i,
  input  logic               core_we_i,
  input  soc_bus_pkg::addr_t core_adr_i,
  input  soc_bus_pkg::data_t core_dat_i,
  input  soc_bus_pkg::sel_t  core_sel_i,
  output soc_bus_pkg::data_t core_dat_o,
  output logic               core_ack_o,
  output logic               core_err_o,
  input  logic               vec_cyc_i,
  input  logic               vec_stb_i,
  input  logic               vec_we_i,
  input  soc_bus_pkg::addr_t vec_adr_i,
  input  soc_bus_pkg::data_t vec_dat_i,
  input  soc_bus_pkg::sel_t  vec_sel_i,
  output soc_bus_pkg::data_t vec_dat_o,
  output logic               vec_ack_o,
  output logic               vec_err_o,
  soc_wb_if.master           l2_bus,
  soc_wb_if.master           uart_bus,
  soc_wb_if.master           ctrl_bus
);

  logic                gnt_core_q;
  logic                gnt_core_d;
  logic                gnt_vec_q;
  logic                gnt_vec_d;
  logic                last_core_q;
  logic                last_core_d;
  logic                core_req;
  logic                vec_req;
  logic                hold;
  logic                act_stb;
  logic                act_we;
  soc_bus_pkg::addr_t  act_adr;
  soc_bus_pkg::data_t  act_dat;
  soc_bus_pkg::sel_t   act_sel;
  soc_bus_pkg::slave_e target;
  logic                unmapped_err_q;
  soc_bus_pkg::data_t  resp_dat;
  logic                resp_ack;
  logic                resp_err;

  //////////////////////////////////////////////////
  // Arbiter
  //////////////////////////////////////////////////

  assign core_req = core_cyc_i & core_stb_i;
  assign vec_req  = vec_cyc_i & vec_stb_i;
  assign hold     = (gnt_core_q & core_cyc_i) | (gnt_vec_q & vec_cyc_i);

  always_comb begin
    gnt_core_d  = gnt_core_q;
    gnt_vec_d   = gnt_vec_q;
    last_core_d = last_core_q;
    if (!hold) begin
      // Vector side wins a tie only when the core was served last
      gnt_core_d = core_req & (~vec_req | ~last_core_q);
      gnt_vec_d  = vec_req & (~core_req | last_core_q);
      if (gnt_core_d || gnt_vec_d) begin
        last_core_d = gnt_core_d;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_core_q     <= 1'b0;
      gnt_vec_q      <= 1'b0;
      last_core_q    <= 1'b0;
      unmapped_err_q <= 1'b0;
    end else begin
      gnt_core_q     <= gnt_core_d;
      gnt_vec_q      <= gnt_vec_d;
      last_core_q    <= last_core_d;
      unmapped_err_q <= act_stb & (target == soc_bus_pkg::SlaveNone) & ~unmapped_err_q;
    end
  end

  //////////////////////////////////////////////////
  // Decode and routing
  //////////////////////////////////////////////////

  assign act_stb = hold & (gnt_vec_q ? vec_stb_i : core_stb_i);
  assign act_we  = gnt_vec_q ? vec_we_i  : core_we_i;
  assign act_adr = gnt_vec_q ? vec_adr_i : core_adr_i;
  assign act_dat = gnt_vec_q ? vec_dat_i : core_dat_i;
  assign act_sel = gnt_vec_q ? vec_sel_i : core_sel_i;

  always_comb begin
    target = soc_bus_pkg::SlaveNone;
    if (act_adr >= soc_bus_pkg::DramBase &&
        act_adr < soc_bus_pkg::DramBase + soc_bus_pkg::DramLength) begin
      target = soc_bus_pkg::SlaveL2;
    end else if (act_adr >= soc_bus_pkg::UartBase &&
                 act_adr < soc_bus_pkg::UartBase + soc_bus_pkg::UartLength) begin
      target = soc_bus_pkg::SlaveUart;
    end else if (act_adr >= soc_bus_pkg::CtrlBase &&
                 act_adr < soc_bus_pkg::CtrlBase + soc_bus_pkg::CtrlLength) begin
      target = soc_bus_pkg::SlaveCtrl;
    end
  end

  assign l2_bus.cyc   = hold & (target == soc_bus_pkg::SlaveL2);
  assign l2_bus.stb   = act_stb & (target == soc_bus_pkg::SlaveL2);
  assign l2_bus.we    = act_we;
  assign l2_bus.adr   = act_adr;
  assign l2_bus.dat_w = act_dat;
  assign l2_bus.sel   = act_sel;

  assign uart_bus.cyc   = hold & (target == soc_bus_pkg::SlaveUart);
  assign uart_bus.stb   = act_stb & (target == soc_bus_pkg::SlaveUart);
  assign uart_bus.we    = act_we;
  assign uart_bus.adr   = act_adr;
  assign uart_bus.dat_w = act_dat;
  assign uart_bus.sel   = act_sel;

  assign ctrl_bus.cyc   = hold & (target == soc_bus_pkg::SlaveCtrl);
  assign ctrl_bus.stb   = act_stb & (target == soc_bus_pkg::SlaveCtrl);
  assign ctrl_bus.we    = act_we;
  assign ctrl_bus.adr   = act_adr;
  assign ctrl_bus.dat_w = act_dat;
  assign ctrl_bus.sel   = act_sel;

  always_comb begin
    resp_dat = '0;
    resp_ack = 1'b0;
    resp_err = 1'b0;
    case (target)
      soc_bus_pkg::SlaveL2: begin
        resp_dat = l2_bus.dat_r;
        resp_ack = l2_bus.ack;
        resp_err = l2_bus.err;
      end
      soc_bus_pkg::SlaveUart: begin
        resp_dat = uart_bus.dat_r;
        resp_ack = uart_bus.ack;
        resp_err = uart_bus.err;
      end
      soc_bus_pkg::SlaveCtrl: begin
        resp_dat = ctrl_bus.dat_r;
        resp_ack = ctrl_bus.ack;
        resp_err = ctrl_bus.err;
      end
      default: begin
        resp_err = unmapped_err_q;
      end
    endcase
  end

  assign core_dat_o = gnt_core_q ? resp_dat : '0;
  assign core_ack_o = gnt_core_q & resp_ack;
  assign core_err_o = gnt_core_q & resp_err;
  assign vec_dat_o  = gnt_vec_q ? resp_dat : '0;
  assign vec_ack_o  = gnt_vec_q & resp_ack;
  assign vec_err_o  = gnt_vec_q & resp_err;

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(gnt_core_q && gnt_vec_q));

  // A slave answer must never land on an idle requester
  a_ack_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (core_ack_o -> core_cyc_i) && (vec_ack_o -> vec_cyc_i));

endmodule

`default_nettype wire

//--- tb_ara_soc.sv
// SoC testbench
// Directed tests of L2, control registers, UART bridge, arbitration and
// unmapped space, with an APB slave model on the UART port

`timescale 1ns/1ps
`default_nettype none

module tb_ara_soc;

  typedef soc_bus_pkg::addr_t addr_t;
  typedef soc_bus_pkg::data_t data_t;
  typedef soc_bus_pkg::sel_t  sel_t;

  localparam int TimeoutCycles = 200;

  logic                   clk_i          = 1'b0;
  logic                   rst_n_i        = 1'b0;
  logic                   core_cyc_i     = 1'b0;
  logic                   core_stb_i     = 1'b0;
  logic                   core_we_i      = 1'b0;
  addr_t                  core_adr_i     = '0;
  data_t                  core_dat_i     = '0;
  sel_t                   core_sel_i     = '0;
  logic                   vec_cyc_i      = 1'b0;
  logic                   vec_stb_i      = 1'b0;
  logic                   vec_we_i       = 1'b0;
  addr_t                  vec_adr_i      = '0;
  data_t                  vec_dat_i      = '0;
  sel_t                   vec_sel_i      = '0;
  soc_bus_pkg::apb_data_t uart_prdata_i  = '0;
  logic                   uart_pready_i  = 1'b0;
  logic                   uart_pslverr_i = 1'b0;
  data_t                  core_dat_o;
  logic                   core_ack_o;
  logic                   core_err_o;
  data_t                  vec_dat_o;
  logic                   vec_ack_o;
  logic                   vec_err_o;
  logic                   uart_psel_o;
  logic                   uart_penable_o;
  logic                   uart_pwrite_o;
  addr_t                  uart_paddr_o;
  soc_bus_pkg::apb_data_t uart_pwdata_o;
  soc_regs_pkg::reg64_t   exit_o;
  soc_regs_pkg::reg64_t   hw_cnt_en_o;

  int          error_count  = 0;
  int          check_count  = 0;
  int          test_count   = 0;
  int          failed_tests = 0;
  int          test_base    = 0;
  logic [31:0] seed         = 32'hea63;

  // APB slave model state
  int          apb_waits    = 0;
  logic        apb_err_mode = 1'b0;
  logic [31:0] apb_regs [4] = '{32'h1111_0000, 32'h2222_0000, 32'h3333_0000, 32'h4444_0000};
  int          apb_count    = 0;
  int          psel_cycles  = 0;
  int          wait_cnt     = 0;
  addr_t       last_paddr   = '0;
  logic        last_pwrite  = 1'b0;
  logic [31:0] last_pwdata  = '0;

  ara_soc dut (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  // Wait states counted in the access phase, one transfer per pready
  always @(negedge clk_i) begin
    if (uart_psel_o) begin
      psel_cycles++;
    end
    if (uart_psel_o && uart_penable_o && !uart_pready_i) begin
      if (wait_cnt == apb_waits) begin
        uart_pready_i  = 1'b1;
        uart_pslverr_i = apb_err_mode;
        uart_prdata_i  = apb_regs[uart_paddr_o[3:2]];
        if (uart_pwrite_o && !apb_err_mode) begin
          apb_regs[uart_paddr_o[3:2]] = uart_pwdata_o;
        end
        last_paddr  = uart_paddr_o;
        last_pwrite = uart_pwrite_o;
        last_pwdata = uart_pwdata_o;
        apb_count++;
      end else begin
        wait_cnt++;
      end
    end else begin
      uart_pready_i  = 1'b0;
      uart_pslverr_i = 1'b0;
      wait_cnt       = 0;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic data_t rand64();
    return {next_rand(), next_rand()};
  endfunction

  function automatic data_t byte_mask(sel_t sel);
    data_t mask;
    for (int i = 0; i < 8; i++) begin
      mask[i*8 +: 8] = {8{sel[i]}};
    end
    return mask;
  endfunction

  task automatic check(input string name, input data_t exp, input data_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic begin_test();
    test_base = error_count;
    test_count++;
  endtask

  task automatic end_test(input string name);
    if (error_count == test_base) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: FAILED with %0d errors", name, error_count - test_base);
      failed_tests++;
    end
  endtask

  // Request held through the edge that ends it, dropped a half cycle later
  task automatic core_access(input logic we, input addr_t adr, input data_t dat,
                             input sel_t sel, output data_t rdata, output logic err);
    int cycles;
    @(negedge clk_i);
    core_cyc_i = 1'b1;
    core_stb_i = 1'b1;
    core_we_i  = we;
    core_adr_i = adr;
    core_dat_i = dat;
    core_sel_i = sel;
    cycles = 0;
    @(negedge clk_i);
    while (!core_ack_o && !core_err_o && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= TimeoutCycles) begin
      abort_run("no ack or err on the core port");
    end else begin
      rdata = core_dat_o;
      err   = core_err_o;
      @(negedge clk_i);
      core_cyc_i = 1'b0;
      core_stb_i = 1'b0;
    end
  endtask

  task automatic vec_access(input logic we, input addr_t adr, input data_t dat,
                            input sel_t sel, output data_t rdata, output logic err);
    int cycles;
    @(negedge clk_i);
    vec_cyc_i = 1'b1;
    vec_stb_i = 1'b1;
    vec_we_i  = we;
    vec_adr_i = adr;
    vec_dat_i = dat;
    vec_sel_i = sel;
    cycles = 0;
    @(negedge clk_i);
    while (!vec_ack_o && !vec_err_o && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= TimeoutCycles) begin
      abort_run("no ack or err on the vector port");
    end else begin
      rdata = vec_dat_o;
      err   = vec_err_o;
      @(negedge clk_i);
      vec_cyc_i = 1'b0;
      vec_stb_i = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    begin_test();
    check("core_ack_o", '0, 64'(core_ack_o));
    check("core_err_o", '0, 64'(core_err_o));
    check("vec_ack_o", '0, 64'(vec_ack_o));
    check("vec_err_o", '0, 64'(vec_err_o));
    check("uart_psel_o", '0, 64'(uart_psel_o));
    check("uart_penable_o", '0, 64'(uart_penable_o));
    check("exit_o", '0, exit_o);
    check("hw_cnt_en_o", '0, hw_cnt_en_o);
    end_test("reset");
  endtask

  task automatic test_l2_bytes();
    addr_t adr;
    data_t first;
    data_t second;
    data_t rd;
    logic  err;
    begin_test();
    adr    = soc_bus_pkg::DramBase + 32'h100;
    first  = rand64();
    second = rand64();
    core_access(1'b1, adr, first, 8'hff, rd, err);
    check("core_err_o", '0, 64'(err));
    core_access(1'b1, adr, second, 8'h5a, rd, err);
    check("core_err_o", '0, 64'(err));
    core_access(1'b0, adr, '0, 8'hff, rd, err);
    check("core_dat_o", (first & ~byte_mask(8'h5a)) | (second & byte_mask(8'h5a)), rd);
    // One full L2 size above wraps onto the same word
    vec_access(1'b0, adr + 32'(soc_bus_pkg::L2NumWords * 8), '0, 8'hff, rd, err);
    check("vec_dat_o", (first & ~byte_mask(8'h5a)) | (second & byte_mask(8'h5a)), rd);
    end_test("l2 byte selects and wrap");
  endtask

  task automatic test_concurrent();
    data_t core_words [4];
    data_t vec_words [4];
    data_t core_rd;
    data_t vec_rd;
    logic  core_err;
    logic  vec_err;
    begin_test();
    for (int i = 0; i < 4; i++) begin
      core_words[i] = rand64();
      vec_words[i]  = rand64();
    end
    fork
      for (int i = 0; i < 4; i++) begin
        core_access(1'b1, soc_bus_pkg::DramBase + 32'h200 + 32'(i * 8), core_words[i],
                    8'hff, core_rd, core_err);
        check("core_err_o", '0, 64'(core_err));
      end
      for (int i = 0; i < 4; i++) begin
        vec_access(1'b1, soc_bus_pkg::DramBase + 32'h400 + 32'(i * 8), vec_words[i],
                   8'hff, vec_rd, vec_err);
        check("vec_err_o", '0, 64'(vec_err));
      end
    join
    fork
      for (int i = 0; i < 4; i++) begin
        core_access(1'b0, soc_bus_pkg::DramBase + 32'h200 + 32'(i * 8), '0, 8'hff,
                    core_rd, core_err);
        check("core_dat_o", core_words[i], core_rd);
      end
      for (int i = 0; i < 4; i++) begin
        vec_access(1'b0, soc_bus_pkg::DramBase + 32'h400 + 32'(i * 8), '0, 8'hff,
                   vec_rd, vec_err);
        check("vec_dat_o", vec_words[i], vec_rd);
      end
    join
    end_test("concurrent requesters");
  endtask

  task automatic test_ctrl();
    data_t wdata;
    data_t rd;
    logic  err;
    begin_test();
    wdata = rand64();
    core_access(1'b1, soc_bus_pkg::CtrlBase + 32'h00, wdata, 8'hff, rd, err);
    check("core_err_o", '0, 64'(err));
    check("exit_o", wdata, exit_o);
    wdata = rand64();
    vec_access(1'b1, soc_bus_pkg::CtrlBase + 32'h08, wdata, 8'hff, rd, err);
    check("vec_err_o", '0, 64'(err));
    check("hw_cnt_en_o", wdata, hw_cnt_en_o);
    core_access(1'b0, soc_bus_pkg::CtrlBase + 32'h10, '0, 8'hff, rd, err);
    check("core_dat_o", {32'h0, soc_bus_pkg::DramBase}, rd);
    core_access(1'b0, soc_bus_pkg::CtrlBase + 32'h18, '0, 8'hff, rd, err);
    check("core_dat_o", {32'h0, soc_bus_pkg::DramBase + soc_bus_pkg::DramLength}, rd);
    core_access(1'b1, soc_bus_pkg::CtrlBase + 32'h10, rand64(), 8'hff, rd, err);
    check("core_err_o", 64'd1, 64'(err));
    core_access(1'b0, soc_bus_pkg::CtrlBase + 32'h10, '0, 8'hff, rd, err);
    check("core_dat_o", {32'h0, soc_bus_pkg::DramBase}, rd);
    end_test("control registers");
  endtask

  task automatic test_uart();
    data_t wdata;
    data_t rd;
    logic  err;
    int    base;
    begin_test();
    apb_waits = 2;
    base      = apb_count;
    wdata     = rand64();
    core_access(1'b1, soc_bus_pkg::UartBase + 32'h8, wdata, 8'hff, rd, err);
    check("core_err_o", '0, 64'(err));
    check("apb transfers", 64'(base + 1), 64'(apb_count));
    check("uart_paddr_o", 64'(soc_bus_pkg::UartBase + 32'h8), 64'(last_paddr));
    check("uart_pwrite_o", 64'd1, 64'(last_pwrite));
    check("uart_pwdata_o", 64'(wdata[31:0]), 64'(last_pwdata));
    vec_access(1'b0, soc_bus_pkg::UartBase + 32'h8, '0, 8'hff, rd, err);
    check("vec_err_o", '0, 64'(err));
    check("vec_dat_o", {32'h0, wdata[31:0]}, rd);
    apb_waits    = 0;
    apb_err_mode = 1'b1;
    core_access(1'b0, soc_bus_pkg::UartBase + 32'h4, '0, 8'hff, rd, err);
    check("core_err_o", 64'd1, 64'(err));
    apb_err_mode = 1'b0;
    end_test("uart bridge");
  endtask

  task automatic test_unmapped();
    data_t                l2_word;
    data_t                rd;
    logic                 err;
    soc_regs_pkg::reg64_t exit_before;
    soc_regs_pkg::reg64_t cnt_before;
    int                   psel_before;
    begin_test();
    l2_word = rand64();
    core_access(1'b1, soc_bus_pkg::DramBase, l2_word, 8'hff, rd, err);
    exit_before = exit_o;
    cnt_before  = hw_cnt_en_o;
    psel_before = psel_cycles;
    vec_access(1'b1, 32'h1000_0000, rand64(), 8'hff, rd, err);
    check("vec_err_o", 64'd1, 64'(err));
    core_access(1'b0, 32'h1000_0000, '0, 8'hff, rd, err);
    check("core_err_o", 64'd1, 64'(err));
    check("uart_psel_o cycles", 64'(psel_before), 64'(psel_cycles));
    check("exit_o", exit_before, exit_o);
    check("hw_cnt_en_o", cnt_before, hw_cnt_en_o);
    core_access(1'b0, soc_bus_pkg::DramBase, '0, 8'hff, rd, err);
    check("core_dat_o", l2_word, rd);
    end_test("unmapped address");
  endtask

  initial begin
    rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset();
    test_l2_bytes();
    test_concurrent();
    test_ctrl();
    test_uart();
    test_unmapped();
    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_apb_bridge.sv
// UART bridge
// Turns one Wishbone request into one APB transfer, setup then access,
// and answers with the zero-extended read data or an error

`timescale 1ns/1ps
`default_nettype none

module uart_apb_bridge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  soc_wb_if.slave                bus,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output soc_bus_pkg::addr_t     uart_paddr_o,
  output soc_bus_pkg::apb_data_t uart_pwdata_o,
  input  soc_bus_pkg::apb_data_t uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i
);

  typedef enum logic [1:0] {
    StIdle,
    StSetup,
    StAccess,
    StRespond
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  soc_bus_pkg::apb_data_t prdata_q;
  logic                   slverr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (bus.cyc && bus.stb) begin
          state_d = StSetup;
        end
      end
      StSetup: begin
        state_d = StAccess;
      end
      StAccess: begin
        if (uart_pready_i) begin
          state_d = StRespond;
        end
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= StIdle;
      slverr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == StAccess && uart_pready_i) begin
        slverr_q <= uart_pslverr_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StAccess && uart_pready_i) begin
      prdata_q <= uart_prdata_i;
    end
  end

  // Request fields are held by the master for the whole transfer
  assign uart_psel_o    = (state_q == StSetup) | (state_q == StAccess);
  assign uart_penable_o = (state_q == StAccess);
  assign uart_pwrite_o  = bus.we;
  assign uart_paddr_o   = bus.adr[soc_bus_pkg::ApbAddrWidth-1:0];
  assign uart_pwdata_o  = bus.dat_w[soc_bus_pkg::ApbDataWidth-1:0];

  assign bus.dat_r = soc_bus_pkg::data_t'(prdata_q);
  assign bus.ack   = (state_q == StRespond) & ~slverr_q;
  assign bus.err   = (state_q == StRespond) & slverr_q;

  // Address, direction and write data stay put from setup through access
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_penable_o |-> uart_psel_o && $stable(uart_paddr_o) &&
                       $stable(uart_pwrite_o) && $stable(uart_pwdata_o));

endmodule

`default_nettype wire
